// File: hw/xc_pkg.sv
// shared constants and types of the photon counter and correlator
// every module and the interface pull these in with a wildcard import
package xc_pkg;

	localparam int NUM_LINES = 4; // detector inputs
	localparam int NUM_PAIRS = 6; // unordered pairs of four lines
	localparam int RESOLUTION = 16; // width of every counter

	localparam int CLK_FREQUENCY = 13300000;
	localparam int BAUD_RATE = 921600;
	localparam int CLKS_PER_BIT = CLK_FREQUENCY / BAUD_RATE; // rounds down to 14
	localparam int HALF_BIT = CLKS_PER_BIT / 2; // offset from the start edge to mid bit
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

	localparam int WINDOW_UNIT = 256; // clocks per step of the command byte
	localparam int WIN_BITS = 8 + $clog2(WINDOW_UNIT); // holds 255 units

	localparam logic [7:0] SYNC_BYTE = 8'h58;
	localparam int FRAME_BYTES = 22; // sync, seq and ten 16 bit words

	// first and second line of each pair, in the order the frame carries them
	localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
	localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

	typedef logic [RESOLUTION-1:0] count_t;
	typedef count_t [NUM_LINES-1:0] line_counts_t;
	typedef count_t [NUM_PAIRS-1:0] pair_counts_t;
	typedef logic [7:0] seq_t; // wraps after 255 frames
	typedef logic [WIN_BITS-1:0] win_t; // window length and timer in clocks

endpackage

// File: hw/xc_frame_if.sv
// carries one finished window snapshot from the counter to the frame sender
// frame_valid is a single cycle strobe and the data is only good in that cycle
`timescale 1ns/1ns

interface xc_frame_if
	import xc_pkg::*;
	();

	logic frame_valid; // end of window strobe, no back-pressure
	line_counts_t line_counts; // rising edges per line
	pair_counts_t pair_counts; // same cycle coincidences per pair
	seq_t seq; // number of this window since reset

	// the counter produces snapshots
	modport source (output frame_valid, output line_counts, output pair_counts, output seq);

	// the sender only watches them
	modport sink (input frame_valid, input line_counts, input pair_counts, input seq);

endinterface

// File: hw/uart_rx.sv
// 8N1 receiver for the single command byte from the host
// cmd_valid pulses one cycle after the middle of a good stop bit
`timescale 1ns/1ns

module uart_rx
	import xc_pkg::*;
	(
	input logic clki,
	input logic rst,
	input logic rx,
	output logic [7:0] cmd_byte,
	output logic cmd_valid
	);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev; // previous synchronized level to spot the start edge
	logic [BIT_CNT_W-1:0] clk_cnt; // clocks within the current bit
	logic [2:0] bit_cnt; // data bits received so far
	logic [7:0] shift_reg;

	assign cmd_byte = shift_reg; // stable from the last data bit until the next byte

	always_ff @(posedge clki) begin
		if (rst) begin
			rx_meta <= 1'b1; // line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			cmd_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			cmd_valid <= 1'b0;
			clk_cnt <= clk_cnt + BIT_CNT_W'(1); // restarted below at each sample point
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync) state <= RX_START; // falling start edge
				end
				RX_START: if (clk_cnt == BIT_CNT_W'(HALF_BIT - 1)) begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					state <= rx_sync ? RX_IDLE : RX_DATA; // a glitch is not a start bit
				end
				RX_DATA: if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
					clk_cnt <= '0;
					shift_reg <= {rx_sync, shift_reg[7:1]}; // LSB arrives first
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) state <= RX_STOP;
				end
				RX_STOP: if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
					cmd_valid <= rx_sync; // framing error drops the byte
					state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

// File: hw/uart_tx.sv
// 8N1 transmitter for one byte per tx_start strobe
// tx_busy is high for ten bit periods starting the cycle after tx_start
`timescale 1ns/1ns

module uart_tx
	import xc_pkg::*;
	(
	input logic clki,
	input logic rst,
	input logic [7:0] tx_byte,
	input logic tx_start,
	output logic tx,
	output logic tx_busy
	);

	logic [8:0] shift_reg; // data bits then the stop bit
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [3:0] bit_cnt; // 0 is the start bit, 9 the stop bit

	always_ff @(posedge clki) begin
		if (rst) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				shift_reg <= {1'b1, tx_byte};
				tx <= 1'b0; // start bit goes out right away
				tx_busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0; // stop bit has been held for a full period
				tx <= 1'b1;
			end else begin
				tx <= shift_reg[0];
				shift_reg <= {1'b0, shift_reg[8:1]};
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + BIT_CNT_W'(1);
		end
	end

	// the line must rest at the idle level between bytes
	assert property (@(posedge clki) disable iff (rst) !tx_busy |-> tx);

endmodule

// File: hw/line_counter.sv
// counts rising edges on each detector line and same cycle coincidences per pair
// a command byte sets the window length and each window end emits one snapshot
`timescale 1ns/1ns

module line_counter
	import xc_pkg::*;
	(
	input logic clki,
	input logic rst,
	input logic line_in [NUM_LINES],
	input logic [7:0] cmd_byte,
	input logic cmd_valid,
	xc_frame_if.source frame
	);

	logic [NUM_LINES-1:0] line_meta; // first synchronizer stage
	logic [NUM_LINES-1:0] line_sync; // second stage, safe to use
	logic [NUM_LINES-1:0] line_prev; // last synchronized value for edge detection
	logic [NUM_LINES-1:0] line_edge;

	line_counts_t line_cnt;
	line_counts_t line_next;
	pair_counts_t pair_cnt;
	pair_counts_t pair_next;

	win_t win_len; // zero means no window runs
	win_t win_cnt;
	seq_t seq_cnt; // sequence number of the window being counted

	assign line_edge = line_sync & ~line_prev; // one cycle per rising edge

	// counts as they stand after this cycle's edges
	always_comb begin
		for (int i = 0; i < NUM_LINES; i++) begin
			line_next[i] = line_cnt[i] + {{(RESOLUTION-1){1'b0}}, line_edge[i]};
		end
		for (int p = 0; p < NUM_PAIRS; p++) begin
			pair_next[p] = pair_cnt[p]
				+ {{(RESOLUTION-1){1'b0}}, line_edge[PAIR_A[p]] & line_edge[PAIR_B[p]]};
		end
	end

	always_ff @(posedge clki) begin
		if (rst) begin
			line_meta <= '0;
			line_sync <= '0;
			line_prev <= '0;
			line_cnt <= '0;
			pair_cnt <= '0;
			win_len <= '0;
			win_cnt <= '0;
			seq_cnt <= '0;
			frame.frame_valid <= 1'b0;
		end else begin
			for (int i = 0; i < NUM_LINES; i++) begin
				line_meta[i] <= line_in[i];
			end
			line_sync <= line_meta;
			line_prev <= line_sync;
			frame.frame_valid <= 1'b0; // strobe unless the window ends below

			if (cmd_valid) begin
				// a command always restarts from empty counters
				win_len <= win_t'(cmd_byte) * win_t'(WINDOW_UNIT);
				win_cnt <= '0;
				line_cnt <= '0;
				pair_cnt <= '0;
			end else if (win_len != '0) begin
				if (win_cnt == win_len - win_t'(1)) begin
					frame.frame_valid <= 1'b1;
					seq_cnt <= seq_cnt + seq_t'(1); // next window carries the next number
					win_cnt <= '0;
					line_cnt <= '0; // next window starts at once
					pair_cnt <= '0;
				end else begin
					win_cnt <= win_cnt + win_t'(1);
					line_cnt <= line_next;
					pair_cnt <= pair_next;
				end
			end
		end
	end

	// snapshot payload, only read in the cycle frame_valid is high
	always_ff @(posedge clki) begin
		if (!cmd_valid && win_len != '0 && win_cnt == win_len - win_t'(1)) begin
			frame.line_counts <= line_next;
			frame.pair_counts <= pair_next;
			frame.seq <= seq_cnt;
		end
	end

	// a stopped counter must stay silent towards the sender
	assert property (@(posedge clki) disable iff (rst) frame.frame_valid |-> win_len != '0);

endmodule

// File: hw/frame_sender.sv
// latches a window snapshot and streams it through the UART transmitter
// order is sync, seq, four line counts and six pair counts, high byte first
// snapshots that arrive while a frame is still going out are dropped
`timescale 1ns/1ns

module frame_sender
	import xc_pkg::*;
	(
	input logic clki,
	input logic rst,
	xc_frame_if.sink frame,
	output logic [7:0] tx_byte,
	output logic tx_start,
	input logic tx_busy
	);

	logic active; // a frame is being sent
	logic [4:0] byte_idx; // next byte to send, FRAME_BYTES when all are issued
	line_counts_t line_snap;
	pair_counts_t pair_snap;
	seq_t seq_snap;

	logic [4:0] word_pos; // byte position counted from the first count word
	logic [3:0] word_idx;
	count_t word;
	logic [7:0] next_byte;

	// select the byte for the current index
	always_comb begin
		word_pos = byte_idx - 5'd2;
		word_idx = word_pos[4:1];
		if (word_idx < 4'(NUM_LINES)) word = line_snap[word_idx[1:0]];
		else word = pair_snap[3'(word_idx - 4'(NUM_LINES))];
		if (byte_idx == 5'd0) next_byte = SYNC_BYTE;
		else if (byte_idx == 5'd1) next_byte = seq_snap;
		else next_byte = word_pos[0] ? word[7:0] : word[15:8]; // even position is the high byte
	end

	always_ff @(posedge clki) begin
		if (rst) begin
			active <= 1'b0;
			byte_idx <= '0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (!active) begin
				if (frame.frame_valid) begin
					active <= 1'b1;
					byte_idx <= '0;
				end
			end else if (!tx_busy && !tx_start) begin
				// tx_busy only rises a cycle after a start so the last start is checked too
				if (byte_idx == 5'(FRAME_BYTES)) begin
					active <= 1'b0; // last byte has left the transmitter
				end else begin
					tx_start <= 1'b1;
					byte_idx <= byte_idx + 5'd1;
				end
			end
		end
	end

	// payload registers
	always_ff @(posedge clki) begin
		if (!active && frame.frame_valid) begin
			line_snap <= frame.line_counts;
			pair_snap <= frame.pair_counts;
			seq_snap <= frame.seq;
		end
		if (active && !tx_busy && !tx_start) tx_byte <= next_byte;
	end

	assert property (@(posedge clki) disable iff (rst) tx_start |-> !tx_busy);

endmodule

// File: hw/xc_board.sv
// board level top of the photon counter and zero lag correlator
// commands come in on rx and one frame per integration window leaves on tx
`timescale 1ns/1ns

module xc_board
	import xc_pkg::*;
	(
	input logic clki,
	input logic rst,
	input logic rx,
	output logic tx,
	input logic line_in [NUM_LINES]
	);

	logic [7:0] cmd_byte;
	logic cmd_valid; // one cycle per good command byte
	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	xc_frame_if frame_bus ();

	uart_rx uart_rx_i (.clki, .rst, .rx, .cmd_byte, .cmd_valid);

	line_counter line_counter_i (
		.clki,
		.rst,
		.line_in,
		.cmd_byte,
		.cmd_valid,
		.frame (frame_bus.source)
	);

	frame_sender frame_sender_i (
		.clki,
		.rst,
		.frame (frame_bus.sink),
		.tx_byte,
		.tx_start,
		.tx_busy
	);

	uart_tx uart_tx_i (.clki, .rst, .tx_byte, .tx_start, .tx, .tx_busy);

endmodule

// File: bench/xc_tb.sv
// testbench for the photon counter board: commands go in over a UART model on rx,
// frames are decoded from tx and compared with counts rebuilt from the pulse log
// run it through compile.f with xc_tb as the top module
`timescale 1ns/1ns

module xc_tb;
	import xc_pkg::*;

	localparam int FRAME_W = 8 * FRAME_BYTES;
	localparam int NUM_WIN = 7; // four windows of 40 units and three of 20
	localparam int IDLE_SLOT = NUM_WIN; // log slot for the pulses sent before any command
	localparam int GUARD = 64; // pulse free cycles at both ends of a window
	localparam int LEN40 = 40 * WINDOW_UNIT;
	localparam int LEN20 = 20 * WINDOW_UNIT;
	localparam int IDLE_CYCLES = 4 * LEN40;
	localparam int QUIET_CYCLES = 4 * LEN20;
	localparam int FRAME_CYCLES = FRAME_BYTES * 10 * CLKS_PER_BIT;
	localparam int RUN_CYCLES = IDLE_CYCLES + 4 * LEN40 + 3 * LEN20 + QUIET_CYCLES
		+ 3 * (GUARD + 10 * CLKS_PER_BIT);
	localparam int WATCHDOG_CYCLES = RUN_CYCLES + 4 * FRAME_CYCLES + 1000;
	// lines allowed to fire in each window, so some pairs stay at zero
	localparam logic [3:0] ALLOW [NUM_WIN] = '{4'hf, 4'h3, 4'hd, 4'h6, 4'hf, 4'ha, 4'h7};

	logic clki;
	logic rst;
	logic rx;
	logic tx;
	logic line_in [NUM_LINES];

	integer seed;
	int cyc = 0; // free running cycle count used to place the windows
	int errors = 0;
	int checks = 0;
	int rx_bytes = 0; // bytes decoded from tx
	int frames_checked = 0;
	int n_pulses = 0;
	logic [3:0] pulse_mask [16384]; // lines raised by each pulse, in order
	int win_first [NUM_WIN+1];
	int win_last [NUM_WIN+1];
	logic [FRAME_W-1:0] frame_q [$];

	xc_board xc_board_i (.clki, .rst, .rx, .tx, .line_in);

	initial begin
		clki = 1'b0;
		forever #4 clki = ~clki;
	end

	always @(posedge clki) cyc <= cyc + 1;

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic wait_until(input int target);
		while (cyc < target) @(posedge clki);
	endtask

	// one 8N1 byte on rx, each bit held for CLKS_PER_BIT cycles
	task automatic send_cmd(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0}; // stop, data, start
		for (int k = 0; k < 10; k++) begin
			@(posedge clki);
			rx <= bits[k];
			repeat (CLKS_PER_BIT - 1) @(posedge clki);
		end
	endtask

	// raise the masked lines together for 2 cycles, then keep all low for low_cycles
	task automatic drive_pulse(input logic [3:0] mask, input int low_cycles);
		@(posedge clki);
		for (int i = 0; i < NUM_LINES; i++) line_in[i] <= mask[i];
		repeat (2) @(posedge clki);
		for (int i = 0; i < NUM_LINES; i++) line_in[i] <= 1'b0;
		repeat (low_cycles - 1) @(posedge clki);
	endtask

	// random pulses in the middle of one window, logged under slot w
	task automatic run_window(input int w, input int start, input int len,
		input logic [3:0] allow);
		logic [3:0] mask;
		int gap;
		win_first[w] = n_pulses;
		wait_until(start + GUARD);
		while (cyc < start + len - GUARD - 12) begin
			mask = 4'($random(seed)) & allow;
			gap = 2 + int'($random(seed) & 7);
			drive_pulse(mask, gap);
			pulse_mask[n_pulses] = mask;
			n_pulses++;
		end
		win_last[w] = n_pulses;
		wait_until(start + len); // nothing driven near the window end
	endtask

	// ten expected counts of window w, first line 0 in the top bits
	function automatic logic [159:0] expected_frame(input int w);
		logic [159:0] r;
		logic [15:0] cnt;
		int p;
		r = '0;
		for (int i = 0; i < NUM_LINES; i++) begin
			cnt = '0;
			for (int k = win_first[w]; k < win_last[w]; k++) if (pulse_mask[k][i]) cnt++;
			r[159-16*i -: 16] = cnt;
		end
		p = NUM_LINES; // pair words follow the line words
		for (int a = 0; a < NUM_LINES - 1; a++) begin
			for (int b = a + 1; b < NUM_LINES; b++) begin
				cnt = '0;
				for (int k = win_first[w]; k < win_last[w]; k++)
					if (pulse_mask[k][a] && pulse_mask[k][b]) cnt++;
				r[159-16*p -: 16] = cnt;
				p++;
			end
		end
		return r;
	endfunction

	// decodes tx at mid bit on falling edges and gathers whole frames
	initial begin : tx_decoder
		logic [7:0] b;
		logic [FRAME_W-1:0] acc;
		int nb;
		nb = 0;
		acc = '0;
		forever begin
			@(negedge clki);
			if (tx === 1'b0) begin
				repeat (HALF_BIT) @(negedge clki); // middle of the start bit
				for (int k = 0; k < 8; k++) begin
					repeat (CLKS_PER_BIT) @(negedge clki);
					b[k] = tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clki);
				if (tx !== 1'b1) begin
					errors++;
					$display("missing stop bit on tx at %0t ns", $time);
				end
				rx_bytes++;
				acc = {acc[FRAME_W-9:0], b};
				nb++;
				if (nb == FRAME_BYTES) begin
					frame_q.push_back(acc);
					nb = 0;
				end
			end
		end
	end

	initial begin : frame_compare
		logic [FRAME_W-1:0] fr;
		logic [159:0] exp_counts;
		forever begin
			@(posedge clki);
			while (frame_q.size() > 0) begin
				fr = frame_q.pop_front();
				if (frames_checked >= NUM_WIN) begin
					errors++;
					$display("a frame arrived after the last planned window at %0t ns", $time);
				end else begin
					exp_counts = expected_frame(frames_checked);
					compare_value(32'(fr[175:168]), 32'(SYNC_BYTE), "sync byte");
					compare_value(32'(fr[167:160]), 32'(frames_checked % 256), "sequence number");
					for (int i = 0; i < 10; i++)
						compare_value(32'(fr[159-16*i -: 16]), 32'(exp_counts[159-16*i -: 16]),
							$sformatf("count word %0d of frame %0d", i, frames_checked));
				end
				frames_checked++;
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clki);
		$display("timed out after %0d cycles with %0d errors", WATCHDOG_CYCLES, errors);
		$display("Errors found");
		$finish;
	end

	initial begin : main_sequence
		int start;
		seed = 21;
		rst <= 1'b1;
		rx <= 1'b1; // UART idle level
		for (int i = 0; i < NUM_LINES; i++) line_in[i] <= 1'b0;
		repeat (3) @(posedge clki);
		rst <= 1'b0;
		@(posedge clki);

		// no command yet, so the pulses must not produce any frame
		run_window(IDLE_SLOT, cyc, IDLE_CYCLES, 4'hf);
		compare_value(32'(rx_bytes), 32'd0, "bytes sent before any command");
		compare_value(32'(tx), 32'd1, "idle tx level");

		send_cmd(8'd40);
		start = cyc; // window starts a few cycles before the task returns
		for (int w = 0; w < 4; w++) begin
			run_window(w, start, LEN40, ALLOW[w]);
			start += LEN40;
		end
		wait_until(start + GUARD); // the command lands inside a window that is thrown away
		send_cmd(8'd20);
		start = cyc;
		for (int w = 4; w < NUM_WIN; w++) begin
			run_window(w, start, LEN20, ALLOW[w]);
			start += LEN20;
		end
		wait_until(start + GUARD);
		send_cmd(8'd0);
		wait_until(cyc + QUIET_CYCLES); // last frame drains, then tx must stay quiet

		compare_value(32'(frames_checked), 32'(NUM_WIN), "frames received");
		compare_value(32'(rx_bytes), 32'(NUM_WIN * FRAME_BYTES), "bytes received");
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: compile.f
hw/xc_pkg.sv
hw/xc_frame_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/line_counter.sv
hw/frame_sender.sv
hw/xc_board.sv
bench/xc_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the photon counter testbench with Verilator and runs it
# exits non-zero when the build, the run or the result fails

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module xc_tb \
	-Mdir obj_dir -o xc_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/xc_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
	exit 1
fi
exit 0
